//--- Makefile
# Verilator build and run of the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# a $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- project.f
source/csr_pkg.sv
source/csr_decode.sv
source/csr_counters.sv
source/csr_trap_regs.sv
source/csr_intr_gen.sv
source/csr_unit.sv
tb/csr_unit_assert.sv
tb/csr_unit_tb.sv

//--- source/csr_counters.sv
module csr_counters #(
    parameter logic [63:0] MTIMECMP_RESET = 64'h0000_0000_8000_0000
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]    csr_addr,
    input  logic                              csr_wren,
    input  logic [csr_pkg::XLEN-1:0]          csr_wdata,
    output logic [63:0]                       cycle,
    output logic [63:0]                       mtimecmp,
    output logic                              timer_pend
);

    logic wr_cmp_lo;
    logic wr_cmp_hi;

    assign wr_cmp_lo = csr_wren & (csr_addr == csr_pkg::csr_addr_mtimecmp);
    assign wr_cmp_hi = csr_wren & (csr_addr == csr_pkg::csr_addr_mtimecmph);

    // free running, also serves as time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    // each half written on its own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= MTIMECMP_RESET;
        end else begin
            if (wr_cmp_lo) begin
                mtimecmp[csr_pkg::XLEN-1:0] <= csr_wdata;
            end
            if (wr_cmp_hi) begin
                mtimecmp[63:csr_pkg::XLEN] <= csr_wdata;
            end
        end
    end

    assign timer_pend = cycle > mtimecmp;   // unsigned 64-bit compare

endmodule

//--- source/csr_decode.sv
module csr_decode (
    input  logic                              instruction_vld,
    input  logic [csr_pkg::XLEN-1:0]          instruction_pld,
    input  logic                              inst_rd_en,
    input  logic [csr_pkg::XLEN-1:0]          rs1_val,
    input  logic [csr_pkg::XLEN-1:0]          csr_rdata,
    output logic [csr_pkg::CSR_ADDR_W-1:0]    csr_addr,
    output logic                              csr_wren,
    output logic [csr_pkg::XLEN-1:0]          csr_wdata,
    output logic                              reg_wr_en
);

    logic [2:0]               funct3;
    logic [4:0]               uimm;
    logic [csr_pkg::XLEN-1:0] uimm_ext;
    logic                     is_csr_op;

    assign csr_addr = instruction_pld[31:20];
    assign funct3   = instruction_pld[14:12];
    assign uimm     = instruction_pld[19:15];   // rs1 field doubles as immediate
    assign uimm_ext = {{(csr_pkg::XLEN-5){1'b0}}, uimm};

    // new value built from the old one
    always_comb begin
        is_csr_op = 1'b1;
        case (csr_pkg::csr_op_e'(funct3))
            csr_pkg::csr_op_rw:  csr_wdata = rs1_val;
            csr_pkg::csr_op_rs:  csr_wdata = csr_rdata | rs1_val;
            csr_pkg::csr_op_rc:  csr_wdata = csr_rdata & ~rs1_val;
            csr_pkg::csr_op_rwi: csr_wdata = uimm_ext;
            csr_pkg::csr_op_rsi: csr_wdata = csr_rdata | uimm_ext;
            csr_pkg::csr_op_rci: csr_wdata = csr_rdata & ~uimm_ext;
            default: begin
                is_csr_op = 1'b0;   // ecall, mret and friends
                csr_wdata = '0;
            end
        endcase
    end

    assign csr_wren  = instruction_vld & is_csr_op;
    assign reg_wr_en = instruction_vld & inst_rd_en;   // old value goes to rd

endmodule

//--- source/csr_intr_gen.sv
module csr_intr_gen (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]    csr_addr,
    input  logic                              csr_wren,
    input  logic [csr_pkg::XLEN-1:0]          csr_wdata,
    input  logic                              intr_meip,
    input  logic                              intr_msip,
    input  logic                              timer_pend,
    input  logic                              mstatus_mie,
    input  logic [csr_pkg::XLEN-1:0]          mie_q,
    input  logic                              intr_rdy,
    output logic [csr_pkg::XLEN-1:0]          mip_q,
    output logic                              intr_vld,
    output logic [csr_pkg::XLEN-1:0]          intr_op
);

    logic [csr_pkg::XLEN-1:0] mip_src;
    logic [csr_pkg::XLEN-1:0] pend;
    logic                     src_any;
    logic                     wr_mip;
    logic                     intr_taken;

    // only the highest live source is captured
    always_comb begin
        mip_src                   = '0;
        mip_src[csr_pkg::mei_bit] = intr_meip;
        mip_src[csr_pkg::msi_bit] = intr_msip & ~intr_meip;
        mip_src[csr_pkg::mti_bit] = timer_pend & ~intr_msip & ~intr_meip;
    end

    assign src_any    = intr_meip | intr_msip | timer_pend;
    assign wr_mip     = csr_wren & (csr_addr == csr_pkg::csr_addr_mip);
    assign intr_taken = intr_vld & intr_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mip_q <= '0;
        end else if (intr_taken) begin
            mip_q <= '0;    // core took the trap
        end else if (src_any) begin
            mip_q <= mip_src;
        end else if (wr_mip) begin
            mip_q <= csr_wdata & csr_pkg::irq_mask;
        end
    end

    assign pend     = mie_q & mip_q;
    assign intr_vld = mstatus_mie & (|pend);

    // external, then software, then timer
    always_comb begin
        if (!intr_vld) begin
            intr_op = '0;
        end else if (pend[csr_pkg::mei_bit]) begin
            intr_op = csr_pkg::cause_mei;
        end else if (pend[csr_pkg::msi_bit]) begin
            intr_op = csr_pkg::cause_msi;
        end else begin
            intr_op = csr_pkg::cause_mti;
        end
    end

endmodule

//--- source/csr_pkg.sv
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // machine trap setup
    localparam logic [CSR_ADDR_W-1:0] csr_addr_mstatus   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_misa      = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_mie       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_mtvec     = 12'h305;

    // machine trap handling
    localparam logic [CSR_ADDR_W-1:0] csr_addr_mscratch  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_mepc      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_mcause    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_mtval     = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_mip       = 12'h344;

    // counters, machine view
    localparam logic [CSR_ADDR_W-1:0] csr_addr_mcycle    = 12'hb00;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_minstret  = 12'hb02;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_mcycleh   = 12'hb80;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_minstreth = 12'hb82;

    // user view of the same counters, time is the cycle counter
    localparam logic [CSR_ADDR_W-1:0] csr_addr_cycle     = 12'hc00;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_time      = 12'hc01;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_instret   = 12'hc02;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_cycleh    = 12'hc80;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_timeh     = 12'hc81;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_instreth  = 12'hc82;

    localparam logic [CSR_ADDR_W-1:0] csr_addr_mhartid   = 12'hf14;

    // non-standard timer compare
    localparam logic [CSR_ADDR_W-1:0] csr_addr_mtimecmp  = 12'h7c0;
    localparam logic [CSR_ADDR_W-1:0] csr_addr_mtimecmph = 12'h7c1;

    // funct3 of the zicsr instructions
    typedef enum logic [2:0] {
        csr_op_rw  = 3'b001,
        csr_op_rs  = 3'b010,
        csr_op_rc  = 3'b011,
        csr_op_rwi = 3'b101,
        csr_op_rsi = 3'b110,
        csr_op_rci = 3'b111
    } csr_op_e;

    localparam logic [XLEN-1:0] cause_msi = 32'd3;
    localparam logic [XLEN-1:0] cause_mti = 32'd7;
    localparam logic [XLEN-1:0] cause_mei = 32'd11;

    localparam logic [XLEN-1:0] misa_value = 32'h4000_0100; // mxl=1, i

    typedef struct packed {
        logic [XLEN-9:0] zero_hi;
        logic            mpie;
        logic [2:0]      zero_mid;
        logic            mie;
        logic [2:0]      zero_lo;
    } mstatus_t;

    // same positions in mie and mip
    localparam int msi_bit = 3;
    localparam int mti_bit = 7;
    localparam int mei_bit = 11;

    localparam logic [XLEN-1:0] irq_mask = (32'd1 << msi_bit) | (32'd1 << mti_bit)
                                         | (32'd1 << mei_bit);

endpackage

//--- source/csr_trap_regs.sv
module csr_trap_regs #(
    parameter logic [csr_pkg::XLEN-1:0] MSCRATCH_RESET = 32'hb000_0000,
    parameter logic [csr_pkg::XLEN-1:0] HART_ID        = 32'd1,
    parameter logic                     MEIE_RESET     = 1'b1
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]    csr_addr,
    input  logic                              csr_wren,
    input  logic [csr_pkg::XLEN-1:0]          csr_wdata,
    input  logic                              trap_vld,
    input  logic [csr_pkg::XLEN-1:0]          trap_pc,
    input  logic [csr_pkg::XLEN-1:0]          trap_cause,
    input  logic [csr_pkg::XLEN-1:0]          trap_tval,
    input  logic                              mret_en,
    input  logic [63:0]                       cycle,
    input  logic [63:0]                       mtimecmp,
    input  logic [63:0]                       instret,
    input  logic [csr_pkg::XLEN-1:0]          mip_q,
    output logic [csr_pkg::XLEN-1:0]          csr_rdata,
    output logic                              mstatus_mie,
    output logic [csr_pkg::XLEN-1:0]          mie_q,
    output logic [csr_pkg::XLEN-1:0]          mtvec_val,
    output logic [csr_pkg::XLEN-1:0]          mepc_val
);

    localparam logic [csr_pkg::XLEN-1:0] MIE_RESET_VAL =
        {{(csr_pkg::XLEN-1){1'b0}}, MEIE_RESET} << csr_pkg::mei_bit;

    csr_pkg::mstatus_t        mstatus_q;
    csr_pkg::mstatus_t        mstatus_wr;
    logic [csr_pkg::XLEN-1:0] mtvec_q;
    logic [csr_pkg::XLEN-1:0] mepc_q;
    logic [csr_pkg::XLEN-1:0] mcause_q;
    logic [csr_pkg::XLEN-1:0] mtval_q;
    logic [csr_pkg::XLEN-1:0] mscratch_q;

    logic wr_mstatus;
    logic wr_mie;
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;
    logic wr_mscratch;

    assign mstatus_wr  = csr_pkg::mstatus_t'(csr_wdata);

    assign wr_mstatus  = csr_wren & (csr_addr == csr_pkg::csr_addr_mstatus);
    assign wr_mie      = csr_wren & (csr_addr == csr_pkg::csr_addr_mie);
    assign wr_mtvec    = csr_wren & (csr_addr == csr_pkg::csr_addr_mtvec);
    assign wr_mepc     = csr_wren & (csr_addr == csr_pkg::csr_addr_mepc);
    assign wr_mcause   = csr_wren & (csr_addr == csr_pkg::csr_addr_mcause);
    assign wr_mtval    = csr_wren & (csr_addr == csr_pkg::csr_addr_mtval);
    assign wr_mscratch = csr_wren & (csr_addr == csr_pkg::csr_addr_mscratch);

    // trap first, then mret, then software
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= '0;
        end else if (trap_vld) begin
            mstatus_q.mpie <= mstatus_q.mie;
            mstatus_q.mie  <= 1'b0;
        end else if (mret_en) begin
            mstatus_q.mie  <= mstatus_q.mpie;
            mstatus_q.mpie <= 1'b1;
        end else if (wr_mstatus) begin
            mstatus_q.mie  <= mstatus_wr.mie;
            mstatus_q.mpie <= mstatus_wr.mpie;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_q <= MIE_RESET_VAL;   // external irq on out of reset
        end else if (wr_mie) begin
            mie_q <= csr_wdata & csr_pkg::irq_mask;
        end
    end

    // mode 2 and 3 are reserved, keep the old mode then
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q <= '0;
        end else if (wr_mtvec) begin
            mtvec_q[csr_pkg::XLEN-1:2] <= csr_wdata[csr_pkg::XLEN-1:2];
            if (!csr_wdata[1]) begin
                mtvec_q[1:0] <= csr_wdata[1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end else if (trap_vld) begin
            mepc_q   <= trap_pc;
            mcause_q <= trap_cause;
            mtval_q  <= trap_cause[csr_pkg::XLEN-1] ? '0 : trap_tval; // no tval on interrupts
        end else begin
            if (wr_mepc) begin
                mepc_q <= csr_wdata;
            end
            if (wr_mcause) begin
                mcause_q <= csr_wdata;
            end
            if (wr_mtval) begin
                mtval_q <= csr_wdata;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch_q <= MSCRATCH_RESET;
        end else if (wr_mscratch) begin
            mscratch_q <= csr_wdata;
        end
    end

    // unknown addresses and 0x3a0 to 0x3ef read zero
    always_comb begin
        case (csr_addr)
            csr_pkg::csr_addr_mstatus:   csr_rdata = mstatus_q;
            csr_pkg::csr_addr_misa:      csr_rdata = csr_pkg::misa_value;
            csr_pkg::csr_addr_mie:       csr_rdata = mie_q;
            csr_pkg::csr_addr_mtvec:     csr_rdata = mtvec_q;
            csr_pkg::csr_addr_mscratch:  csr_rdata = mscratch_q;
            csr_pkg::csr_addr_mepc:      csr_rdata = mepc_q;
            csr_pkg::csr_addr_mcause:    csr_rdata = mcause_q;
            csr_pkg::csr_addr_mtval:     csr_rdata = mtval_q;
            csr_pkg::csr_addr_mip:       csr_rdata = mip_q;
            csr_pkg::csr_addr_mhartid:   csr_rdata = HART_ID;
            csr_pkg::csr_addr_mcycle,
            csr_pkg::csr_addr_cycle,
            csr_pkg::csr_addr_time:      csr_rdata = cycle[csr_pkg::XLEN-1:0];
            csr_pkg::csr_addr_mcycleh,
            csr_pkg::csr_addr_cycleh,
            csr_pkg::csr_addr_timeh:     csr_rdata = cycle[63:csr_pkg::XLEN];
            csr_pkg::csr_addr_minstret,
            csr_pkg::csr_addr_instret:   csr_rdata = instret[csr_pkg::XLEN-1:0];
            csr_pkg::csr_addr_minstreth,
            csr_pkg::csr_addr_instreth:  csr_rdata = instret[63:csr_pkg::XLEN];
            csr_pkg::csr_addr_mtimecmp:  csr_rdata = mtimecmp[csr_pkg::XLEN-1:0];
            csr_pkg::csr_addr_mtimecmph: csr_rdata = mtimecmp[63:csr_pkg::XLEN];
            default:                     csr_rdata = '0;
        endcase
    end

    assign mstatus_mie = mstatus_q.mie;
    assign mtvec_val   = mtvec_q;
    assign mepc_val    = mepc_q;

endmodule

//--- source/csr_unit.sv
module csr_unit #(
    parameter logic [csr_pkg::XLEN-1:0] MSCRATCH_RESET = 32'hb000_0000,
    parameter logic [csr_pkg::XLEN-1:0] HART_ID        = 32'd1,
    parameter logic [63:0]              MTIMECMP_RESET = 64'h0000_0000_8000_0000,
    parameter logic                     MEIE_RESET     = 1'b1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          instruction_vld,
    input  logic [csr_pkg::XLEN-1:0]      instruction_pld,
    input  logic [4:0]                    inst_rd_idx,
    input  logic                          inst_rd_en,
    input  logic [csr_pkg::XLEN-1:0]      rs1_val,
    input  logic [63:0]                   instret,
    input  logic                          trap_vld,
    input  logic [csr_pkg::XLEN-1:0]      trap_pc,
    input  logic [csr_pkg::XLEN-1:0]      trap_cause,
    input  logic [csr_pkg::XLEN-1:0]      trap_tval,
    input  logic                          mret_en,
    input  logic                          intr_meip,
    input  logic                          intr_msip,
    input  logic                          intr_rdy,
    output logic [4:0]                    reg_index,
    output logic                          reg_wr_en,
    output logic [csr_pkg::XLEN-1:0]      reg_val,
    output logic                          intr_vld,
    output logic [csr_pkg::XLEN-1:0]      intr_op,
    output logic [csr_pkg::XLEN-1:0]      mtvec_val,
    output logic [csr_pkg::XLEN-1:0]      mepc_val
);

    logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr;
    logic                           csr_wren;
    logic [csr_pkg::XLEN-1:0]       csr_wdata;
    logic [csr_pkg::XLEN-1:0]       csr_rdata;
    logic [63:0]                    cycle;
    logic [63:0]                    mtimecmp;
    logic                           timer_pend;
    logic [csr_pkg::XLEN-1:0]       mip_q;
    logic [csr_pkg::XLEN-1:0]       mie_q;
    logic                           mstatus_mie;

    assign reg_index = inst_rd_idx;
    assign reg_val   = csr_rdata;   // old value, same cycle as the strobe

    csr_decode u_decode (
        .instruction_vld (instruction_vld),
        .instruction_pld (instruction_pld),
        .inst_rd_en      (inst_rd_en),
        .rs1_val         (rs1_val),
        .csr_rdata       (csr_rdata),
        .csr_addr        (csr_addr),
        .csr_wren        (csr_wren),
        .csr_wdata       (csr_wdata),
        .reg_wr_en       (reg_wr_en)
    );

    csr_counters #(
        .MTIMECMP_RESET (MTIMECMP_RESET)
    ) u_counters (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_addr   (csr_addr),
        .csr_wren   (csr_wren),
        .csr_wdata  (csr_wdata),
        .cycle      (cycle),
        .mtimecmp   (mtimecmp),
        .timer_pend (timer_pend)
    );

    csr_trap_regs #(
        .MSCRATCH_RESET (MSCRATCH_RESET),
        .HART_ID        (HART_ID),
        .MEIE_RESET     (MEIE_RESET)
    ) u_trap_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_addr    (csr_addr),
        .csr_wren    (csr_wren),
        .csr_wdata   (csr_wdata),
        .trap_vld    (trap_vld),
        .trap_pc     (trap_pc),
        .trap_cause  (trap_cause),
        .trap_tval   (trap_tval),
        .mret_en     (mret_en),
        .cycle       (cycle),
        .mtimecmp    (mtimecmp),
        .instret     (instret),
        .mip_q       (mip_q),
        .csr_rdata   (csr_rdata),
        .mstatus_mie (mstatus_mie),
        .mie_q       (mie_q),
        .mtvec_val   (mtvec_val),
        .mepc_val    (mepc_val)
    );

    csr_intr_gen u_intr_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_addr    (csr_addr),
        .csr_wren    (csr_wren),
        .csr_wdata   (csr_wdata),
        .intr_meip   (intr_meip),
        .intr_msip   (intr_msip),
        .timer_pend  (timer_pend),
        .mstatus_mie (mstatus_mie),
        .mie_q       (mie_q),
        .intr_rdy    (intr_rdy),
        .mip_q       (mip_q),
        .intr_vld    (intr_vld),
        .intr_op     (intr_op)
    );

endmodule

//--- tb/csr_unit_assert.sv
module csr_unit_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     instruction_vld,
    input logic                     reg_wr_en,
    input logic                     intr_vld,
    input logic [csr_pkg::XLEN-1:0] intr_op
);

    timeunit 1ns;
    timeprecision 1ps;

    // nothing pending right out of reset
    intr_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !intr_vld)
        else $error("intr_vld high in the first cycle after reset");

    rd_write_needs_strobe: assert property (
        @(posedge clk) disable iff (!rst_n) reg_wr_en |-> instruction_vld)
        else $error("reg_wr_en high without instruction_vld");

    intr_has_cause: assert property (
        @(posedge clk) disable iff (!rst_n) intr_vld |-> (intr_op != '0))
        else $error("intr_vld high with a zero intr_op");

endmodule

bind csr_unit csr_unit_assert u_assert (.*);

//--- tb/csr_unit_tb.sv
module csr_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // whole run is under 200 cycles
    localparam int max_cycles = 2000;

    logic        clk;
    logic        rst_n;
    logic        instruction_vld;
    logic [31:0] instruction_pld;
    logic [4:0]  inst_rd_idx;
    logic        inst_rd_en;
    logic [31:0] rs1_val;
    logic [63:0] instret;
    logic        trap_vld;
    logic [31:0] trap_pc;
    logic [31:0] trap_cause;
    logic [31:0] trap_tval;
    logic        mret_en;
    logic        intr_meip;
    logic        intr_msip;
    logic        intr_rdy;
    logic [4:0]  reg_index;
    logic        reg_wr_en;
    logic [31:0] reg_val;
    logic        intr_vld;
    logic [31:0] intr_op;
    logic [31:0] mtvec_val;
    logic [31:0] mepc_val;

    string       test_name;
    logic [31:0] rng_state = 32'ha07e;
    logic [4:0]  rd_idx_next = 5'd1;
    int          cycle_count = 0;

    csr_unit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            stop_with_failure("timeout, the tests did not finish in time");
        end
    end

    task automatic check(input string item, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %h, actual %h", test_name, item, exp, act);
            stop_with_failure("value mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // write, set or clear by the low funct3 bits
    function automatic logic [31:0] rmw_result(input logic [2:0] f3, input logic [31:0] old,
                                               input logic [31:0] src);
        case (f3[1:0])
            2'b01:   return src;
            2'b10:   return old | src;
            default: return old & ~src;
        endcase
    endfunction

    // one csr instruction, old value sampled mid cycle
    task automatic csr_exec(input logic [11:0] addr, input logic [2:0] f3,
                            input logic [4:0] uimm, input logic [31:0] rs1,
                            input logic rd_en, output logic [31:0] old);
        logic [4:0] rd_idx;
        rd_idx      = rd_idx_next;
        rd_idx_next = rd_idx_next + 5'd3;   // walks through all indices
        @(posedge clk);
        #2;
        instruction_vld = 1'b1;
        instruction_pld = {addr, uimm, f3, 5'd5, 7'h73};
        rs1_val         = rs1;
        inst_rd_en      = rd_en;
        inst_rd_idx     = rd_idx;
        @(negedge clk);
        old = reg_val;
        check("reg_wr_en", 32'(rd_en), 32'(reg_wr_en));
        check("reg_index", 32'(rd_idx), 32'(reg_index));
        @(posedge clk);
        #2;
        instruction_vld = 1'b0;
        inst_rd_en      = 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
        csr_exec(addr, csr_pkg::csr_op_rs, 5'd0, 32'd0, 1'b1, data);
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused_old;
        csr_exec(addr, csr_pkg::csr_op_rw, 5'd0, data, 1'b1, unused_old);
    endtask

    task automatic pulse_trap(input logic [31:0] pc, input logic [31:0] cause,
                              input logic [31:0] tval);
        @(posedge clk);
        #2;
        trap_vld   = 1'b1;
        trap_pc    = pc;
        trap_cause = cause;
        trap_tval  = tval;
        @(posedge clk);
        #2;
        trap_vld = 1'b0;
    endtask

    task automatic pulse_mret();
        @(posedge clk);
        #2;
        mret_en = 1'b1;
        @(posedge clk);
        #2;
        mret_en = 1'b0;
    endtask

    task automatic test_reset_values();
        logic [31:0] data;
        test_name = "reset_values";
        csr_read(csr_pkg::csr_addr_mscratch, data);
        check("mscratch", 32'hb000_0000, data);
        csr_read(csr_pkg::csr_addr_mhartid, data);
        check("mhartid", 32'd1, data);
        csr_read(csr_pkg::csr_addr_misa, data);
        check("misa", 32'h4000_0100, data);     // mxl 32 bit, base i
        csr_read(csr_pkg::csr_addr_mtimecmp, data);
        check("mtimecmp low", 32'h8000_0000, data);
        csr_read(csr_pkg::csr_addr_mepc, data);
        check("mepc", 32'd0, data);
        csr_read(csr_pkg::csr_addr_minstret, data);
        check("minstret", instret[31:0], data);
        csr_exec(csr_pkg::csr_addr_mscratch, csr_pkg::csr_op_rs, 5'd0, 32'd0, 1'b0, data);
    endtask

    task automatic test_read_modify_write();
        logic [2:0]  ops [0:5];
        logic [31:0] init;
        logic [31:0] rs1;
        logic [4:0]  uimm;
        logic [31:0] src;
        logic [31:0] old;
        logic [31:0] now;
        test_name = "read_modify_write";
        ops = '{csr_pkg::csr_op_rw, csr_pkg::csr_op_rs, csr_pkg::csr_op_rc,
                csr_pkg::csr_op_rwi, csr_pkg::csr_op_rsi, csr_pkg::csr_op_rci};
        for (int i = 0; i < 6; i++) begin
            rng_state = xorshift32(rng_state);
            init      = rng_state;
            rng_state = xorshift32(rng_state);
            rs1       = rng_state;
            uimm      = rs1[9:5];
            csr_write(csr_pkg::csr_addr_mscratch, init);
            csr_exec(csr_pkg::csr_addr_mscratch, ops[i], uimm, rs1, 1'b1, old);
            check($sformatf("old value, funct3 %0d", ops[i]), init, old);
            src = ops[i][2] ? {27'd0, uimm} : rs1;   // immediate forms ignore rs1
            csr_read(csr_pkg::csr_addr_mscratch, now);
            check($sformatf("new value, funct3 %0d", ops[i]), rmw_result(ops[i], init, src), now);
        end
    endtask

    task automatic test_mtvec();
        logic [31:0] data;
        test_name = "mtvec_legalize";
        csr_write(csr_pkg::csr_addr_mtvec, 32'h8000_0100);
        csr_read(csr_pkg::csr_addr_mtvec, data);
        check("direct mode", 32'h8000_0100, data);
        csr_write(csr_pkg::csr_addr_mtvec, 32'h2000_0202);
        csr_read(csr_pkg::csr_addr_mtvec, data);
        check("reserved mode kept old", 32'h2000_0200, data);
        csr_write(csr_pkg::csr_addr_mtvec, 32'h3000_0001);
        csr_read(csr_pkg::csr_addr_mtvec, data);
        check("vectored mode", 32'h3000_0001, data);
        csr_write(csr_pkg::csr_addr_mtvec, 32'h4000_0003);
        csr_read(csr_pkg::csr_addr_mtvec, data);
        check("reserved after vectored", 32'h4000_0001, data);
        check("mtvec_val", 32'h4000_0001, mtvec_val);
    endtask

    task automatic test_trap_mret();
        logic [31:0] data;
        test_name = "trap_mret";
        csr_exec(csr_pkg::csr_addr_mstatus, csr_pkg::csr_op_rsi, 5'd8, 32'd0, 1'b1, data);
        pulse_trap(32'h0000_1234, 32'd2, 32'hdead_beef);   // illegal instruction
        csr_read(csr_pkg::csr_addr_mepc, data);
        check("mepc", 32'h0000_1234, data);
        check("mepc_val", 32'h0000_1234, mepc_val);
        csr_read(csr_pkg::csr_addr_mcause, data);
        check("mcause", 32'd2, data);
        csr_read(csr_pkg::csr_addr_mtval, data);
        check("mtval", 32'hdead_beef, data);
        csr_read(csr_pkg::csr_addr_mstatus, data);
        check("mstatus after trap", 32'h0000_0080, data);
        pulse_mret();
        csr_read(csr_pkg::csr_addr_mstatus, data);
        check("mstatus after mret", 32'h0000_0088, data);
        // interrupt cause, tval dropped
        pulse_trap(32'h0000_2000, 32'h8000_000b, 32'h1111_2222);
        csr_read(csr_pkg::csr_addr_mcause, data);
        check("mcause irq", 32'h8000_000b, data);
        csr_read(csr_pkg::csr_addr_mtval, data);
        check("mtval irq", 32'd0, data);
        pulse_mret();
        csr_read(csr_pkg::csr_addr_mstatus, data);
        check("mstatus after second mret", 32'h0000_0088, data);
    endtask

    task automatic test_intr_priority();
        logic [31:0] data;
        test_name = "intr_priority";
        csr_write(csr_pkg::csr_addr_mie, 32'h0000_0808);   // msie and meie
        @(posedge clk);
        #2;
        intr_msip = 1'b1;
        @(posedge clk);
        #2;
        intr_msip = 1'b0;
        @(negedge clk);
        check("intr_vld on msip", 32'd1, 32'(intr_vld));
        check("intr_op on msip", 32'd3, intr_op);
        @(posedge clk);
        #2;
        intr_msip = 1'b1;
        intr_meip = 1'b1;
        @(posedge clk);
        #2;
        intr_msip = 1'b0;
        intr_meip = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check("intr_op held", 32'd11, intr_op);
        end
        @(posedge clk);
        #2;
        intr_rdy = 1'b1;
        @(negedge clk);
        check("intr_vld while taken", 32'd1, 32'(intr_vld));
        @(posedge clk);
        #2;
        intr_rdy = 1'b0;
        @(negedge clk);
        check("intr_vld after ack", 32'd0, 32'(intr_vld));
        csr_read(csr_pkg::csr_addr_mip, data);
        check("mip after ack", 32'd0, data);
    endtask

    task automatic test_timer();
        logic [31:0] now;
        logic [31:0] later;
        logic        seen;
        test_name = "timer";
        seen = 1'b0;
        csr_write(csr_pkg::csr_addr_mie, 32'h0000_0080);   // mtie only
        csr_read(csr_pkg::csr_addr_mcycle, now);
        csr_write(csr_pkg::csr_addr_mtimecmp, now + 32'd20);
        for (int i = 0; i < 40 && !seen; i++) begin
            @(negedge clk);
            seen = intr_vld;
        end
        if (!seen) begin
            stop_with_failure("timer interrupt did not come within 40 cycles");
        end
        check("intr_op timer", 32'd7, intr_op);
        csr_read(csr_pkg::csr_addr_mcycle, now);
        csr_read(csr_pkg::csr_addr_mcycle, later);
        if (later <= now) begin
            stop_with_failure("cycle counter did not increase between two reads");
        end
    endtask

    initial begin
        rst_n           = 1'b0;
        instruction_vld = 1'b0;
        instruction_pld = 32'd0;
        inst_rd_idx     = 5'd0;
        inst_rd_en      = 1'b0;
        rs1_val         = 32'd0;
        instret         = 64'h0000_0002_0000_0010;
        trap_vld        = 1'b0;
        trap_pc         = 32'd0;
        trap_cause      = 32'd0;
        trap_tval       = 32'd0;
        mret_en         = 1'b0;
        intr_meip       = 1'b0;
        intr_msip       = 1'b0;
        intr_rdy        = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        test_name = "after_reset";
        check("intr_vld", 32'd0, 32'(intr_vld));
        test_reset_values();
        test_read_modify_write();
        test_mtvec();
        test_trap_mret();
        test_intr_priority();
        test_timer();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
